// ==== flist.f ====
+incdir+include
verilog/clkrst_pkg.sv
verilog/rst_ctrl_regs.sv
verilog/chan_rst_mon.sv
verilog/status_readback.sv
verilog/clkrst_top.sv
testbench/tb_clkrst.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= tb_clkrst
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SHELL := /bin/bash

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), scan $(LOG) for failure"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/clkrst_tests.svh ====
////////////////////////////////////////
// directed tests for the rx clock/reset
// supervisor, bus access and compare helpers
////////////////////////////////////////
`ifndef CLKRST_TESTS_SVH
`define CLKRST_TESTS_SVH

////////////////////////////////////////
// helpers
////////////////////////////////////////
// drive point, a fixed delay past the rising edge
task automatic next_cycle();
  @(posedge iCLK_SERDES_RXREC);
  #DRIVE_DLY;
endtask

task automatic expect_eq(input string name, input mm_data_t got, input mm_data_t exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("mismatch %s: got 0x%0h expected 0x%0h (cycle %0d)",
             name, got, exp, cycle_cnt);
  end
endtask

// single write strobe, lands on the next edge
task automatic write_reg(input mm_addr_t addr, input mm_data_t data);
  mm_req.wr_en   = 1'b1;
  mm_req.addr    = addr;
  mm_req.wr_data = data;
  next_cycle();
  mm_req.wr_en   = 1'b0;
endtask

// valid must be a one cycle pulse right after the rd_en edge
task automatic read_reg(input mm_addr_t addr, output mm_data_t data);
  expect_eq("mm_rd_data_v before rd_en", mm_data_t'(mm_rd_data_v), '0);
  mm_req.rd_en = 1'b1;
  mm_req.addr  = addr;
  next_cycle();
  mm_req.rd_en = 1'b0;
  data = mm_rd_data;
  expect_eq("mm_rd_data_v one cycle after rd_en", mm_data_t'(mm_rd_data_v), 32'h1);
  next_cycle();
  expect_eq("mm_rd_data_v two cycles after rd_en", mm_data_t'(mm_rd_data_v), '0);
endtask

// walk the release chain, held outputs rise only on the last edge
task automatic check_release(input string tag, input logic [NUM_CHAN-1:0] held,
                             input logic chip_held);
  logic [NUM_CHAN-1:0] chan_exp;
  logic                chip_exp;
  for (int e = 1; e <= RST_STAGES + 1; e++)
  begin
    next_cycle();
    chan_exp = (e > RST_STAGES) ? ALL_CHAN : ~held;
    chip_exp = (e > RST_STAGES) || !chip_held;  // untouched chip stays high
    expect_eq({"chan_rst_n ", tag}, mm_data_t'(chan_rst_n), mm_data_t'(chan_exp));
    expect_eq({"chip_rst_n ", tag}, mm_data_t'(chip_rst_n), mm_data_t'(chip_exp));
  end
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////
// 1: power-on release, control reads zero
task automatic reset_release();
  mm_data_t rd;
  rst_n = 1'b1;
  check_release("after rst_n", ALL_CHAN, 1'b1);
  read_reg(ADDR_CTRL, rd);
  expect_eq("ADDR_CTRL after reset", rd, '0);
endtask

// 2: random channel bits drop only their own outputs
task automatic chan_reset_bits();
  logic [NUM_CHAN-1:0] bits;
  logic [NUM_CHAN-1:0] chan_exp;
  mm_data_t            rd;
  repeat (3)
  begin
    bits = NUM_CHAN'($urandom());
    if (bits == '0)
      bits[0] = 1'b1;  // at least one channel
    chan_exp = ~bits;
    write_reg(ADDR_CTRL, mm_data_t'(bits));
    next_cycle();
    expect_eq("chan_rst_n one edge after write", mm_data_t'(chan_rst_n),
              mm_data_t'(ALL_CHAN));
    next_cycle();
    expect_eq("chan_rst_n two edges after write", mm_data_t'(chan_rst_n),
              mm_data_t'(chan_exp));
    read_reg(ADDR_CTRL, rd);
    expect_eq("ADDR_CTRL channel bits", rd, mm_data_t'(bits));
    write_reg(ADDR_CTRL, '0);
    check_release("after channel bits clear", bits, 1'b0);
  end
endtask

// 3: chip bit and lost pll lock take everything down
task automatic chip_and_pll_reset();
  mm_data_t rd;
  mm_data_t chip_word;
  chip_word = (mm_data_t'(1) << CTRL_CHIP_RST_BIT) | mm_data_t'(NUM_CHAN'($urandom()));
  write_reg(ADDR_CTRL, chip_word);
  repeat (2) next_cycle();
  expect_eq("chip_rst_n with chip bit", mm_data_t'(chip_rst_n), '0);
  expect_eq("chan_rst_n with chip bit", mm_data_t'(chan_rst_n), '0);
  read_reg(ADDR_CTRL, rd);
  expect_eq("ADDR_CTRL chip bit", rd, chip_word);
  write_reg(ADDR_CTRL, '0);
  check_release("after chip bit clear", ALL_CHAN, 1'b1);
  pll_locked = 1'b0;  // lock lost
  repeat (2) next_cycle();
  expect_eq("chip_rst_n without lock", mm_data_t'(chip_rst_n), '0);
  expect_eq("chan_rst_n without lock", mm_data_t'(chan_rst_n), '0);
  read_reg(ADDR_STATUS, rd);
  expect_eq("ADDR_STATUS bit 0 without lock", mm_data_t'(rd[0]), '0);
  pll_locked = 1'b1;
  check_release("after relock", ALL_CHAN, 1'b1);
  read_reg(ADDR_STATUS, rd);
  expect_eq("ADDR_STATUS after relock", rd, 32'h1);
endtask

// 4: one ready pulse sticks until a channel reset
task automatic sticky_ready();
  int                  ch;
  logic [NUM_CHAN-1:0] held;
  mm_data_t            rd;
  mm_data_t            stat_exp;
  ch       = int'($urandom() % NUM_CHAN);
  held     = '0;
  held[ch] = 1'b1;
  stat_exp = mm_data_t'(1) | (mm_data_t'(1) << (STAT_RX_READY_LSB + ch));
  rx_ready[ch] = 1'b1;
  next_cycle();
  rx_ready[ch] = 1'b0;  // gone again
  read_reg(ADDR_STATUS, rd);
  expect_eq("ADDR_STATUS sticky set", rd, stat_exp);
  read_reg(ADDR_STATUS, rd);
  expect_eq("ADDR_STATUS sticky held", rd, stat_exp);
  write_reg(ADDR_CTRL, mm_data_t'(held));
  repeat (2) next_cycle();
  read_reg(ADDR_STATUS, rd);
  expect_eq("ADDR_STATUS sticky cleared", rd, 32'h1);
  write_reg(ADDR_CTRL, '0);
  check_release("after sticky clear", held, 1'b0);
  read_reg(ADDR_STATUS, rd);
  expect_eq("ADDR_STATUS after channel release", rd, 32'h1);
endtask

// 5: full rate, half rate, idle, and a channel held in reset
task automatic freq_counters();
  mm_data_t            rd;
  mm_data_t            cnt_exp [NUM_CHAN];
  logic [NUM_CHAN-1:0] held;
  held           = '0;
  held[NUM_CHAN-1] = 1'b1;
  tick_mode      = '{TICK_EVERY, TICK_HALF, TICK_OFF, TICK_EVERY};
  cnt_exp        = '{WINDOW_CYCLES, WINDOW_CYCLES / 2, 0, 0};
  write_reg(ADDR_CTRL, mm_data_t'(held));
  repeat (2 * WINDOW_CYCLES + 2) next_cycle();  // at least one whole window
  for (int i = 0; i < NUM_CHAN; i++)
  begin
    read_reg(mm_addr_t'(ADDR_FREQ_BASE + i), rd);
    expect_eq($sformatf("freq count ch%0d", i), rd, cnt_exp[i]);
  end
  tick_mode = '{TICK_OFF, TICK_OFF, TICK_OFF, TICK_OFF};
  write_reg(ADDR_CTRL, '0);
  check_release("after counter test", held, 1'b0);
endtask

// 6: holes in the map read zero
task automatic unmapped_read();
  mm_data_t rd;
  read_reg(mm_addr_t'(ADDR_FREQ_BASE + NUM_CHAN), rd);
  expect_eq("first address past the counters", rd, '0);
  read_reg(4'hf, rd);
  expect_eq("last address", rd, '0);
endtask

`endif

// ==== testbench/tb_clkrst.sv ====
////////////////////////////////////////
// testbench for the serdes rx clock and
// reset supervisor, directed tests only
////////////////////////////////////////
module tb_clkrst;
  timeunit 1ns;
  timeprecision 1ns;

  import clkrst_pkg::*;

  localparam int NUM_CHAN      = 4;
  localparam int RST_STAGES    = 3;
  localparam int WINDOW_CYCLES = 64;
  localparam int DRIVE_DLY     = 10;   // ns past the rising edge
  localparam int RST_CYCLES    = 5;

  // rough run length, release chains and reads plus two windows
  localparam int TEST_CYCLES    = 40 * (RST_STAGES + 1) + 2 * WINDOW_CYCLES + 40;
  localparam int TIMEOUT_CYCLES = 6 * TEST_CYCLES;  // about 2000

  // tick driver modes
  localparam int TICK_OFF   = 0;
  localparam int TICK_EVERY = 1;
  localparam int TICK_HALF  = 2;

  localparam logic [NUM_CHAN-1:0] ALL_CHAN = '1;

  logic                iCLK_SERDES_RXREC;
  logic                rst_n;
  mm_req_t             mm_req;
  logic                pll_locked;
  logic [NUM_CHAN-1:0] rx_ready;
  logic [NUM_CHAN-1:0] clk_tick;
  logic [NUM_CHAN-1:0] chan_rst_n;
  logic                chip_rst_n;
  mm_data_t            mm_rd_data;
  logic                mm_rd_data_v;

  int   tick_mode [NUM_CHAN];
  logic tick_phase;           // half rate toggle
  int   cycle_cnt = 0;
  int   errors    = 0;
  int   checks    = 0;

  clkrst_top #(
    .NUM_CHAN      (NUM_CHAN),
    .RST_STAGES    (RST_STAGES),
    .WINDOW_CYCLES (WINDOW_CYCLES)
  ) uut (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .rst_n             (rst_n),
    .mm_req            (mm_req),
    .mm_rd_data        (mm_rd_data),
    .mm_rd_data_v      (mm_rd_data_v),
    .pll_locked        (pll_locked),
    .rx_ready          (rx_ready),
    .clk_tick          (clk_tick),
    .chan_rst_n        (chan_rst_n),
    .chip_rst_n        (chip_rst_n)
  );

  `include "clkrst_tests.svh"

  ////////////////////////////////////////
  // clock, ticks, timeout
  ////////////////////////////////////////
  initial
  begin
    iCLK_SERDES_RXREC = 1'b0;
    forever #50 iCLK_SERDES_RXREC = ~iCLK_SERDES_RXREC;  // 100 ns
  end

  // one strobe per channel, stands in for the recovered clocks
  initial
  begin
    clk_tick   = '0;
    tick_phase = 1'b0;
    forever
    begin
      @(posedge iCLK_SERDES_RXREC);
      #DRIVE_DLY;
      tick_phase = ~tick_phase;
      for (int i = 0; i < NUM_CHAN; i++)
        clk_tick[i] = (tick_mode[i] == TICK_EVERY) || (tick_mode[i] == TICK_HALF && tick_phase);
    end
  end

  always @(posedge iCLK_SERDES_RXREC)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial
  begin
    void'($urandom(29781));
    rst_n      = 1'b0;
    mm_req     = '0;
    pll_locked = 1'b1;
    rx_ready   = '0;
    tick_mode  = '{TICK_OFF, TICK_OFF, TICK_OFF, TICK_OFF};
    repeat (RST_CYCLES) next_cycle();  // reset held
    reset_release();
    chan_reset_bits();
    chip_and_pll_reset();
    sticky_ready();
    freq_counters();
    unmapped_read();
    $display("errors: %0d of %0d checks failed", errors, checks);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== verilog/clkrst_top.sv ====
////////////////////////////////////////
// serdes rx reset / clock supervisor
// control registers, one monitor per
// channel and register readback
////////////////////////////////////////
module clkrst_top
#(
  parameter int NUM_CHAN      = 4,
  parameter int RST_STAGES    = 3,
  parameter int WINDOW_CYCLES = 1000
)
(
  input  logic                 iCLK_SERDES_RXREC,
  input  logic                 rst_n,
  ////////////////////////////////////////
  // register bus
  ////////////////////////////////////////
  input  clkrst_pkg::mm_req_t  mm_req,
  output clkrst_pkg::mm_data_t mm_rd_data,
  output logic                 mm_rd_data_v,
  ////////////////////////////////////////
  // serdes side
  ////////////////////////////////////////
  input  logic                 pll_locked,   // gates every reset output
  input  logic [NUM_CHAN-1:0]  rx_ready,
  input  logic [NUM_CHAN-1:0]  clk_tick,     // stand-in for each recovered clock
  output logic [NUM_CHAN-1:0]  chan_rst_n,
  output logic                 chip_rst_n
);

  import clkrst_pkg::*;

  mm_data_t            ctrl_word;
  logic [NUM_CHAN-1:0] chan_rst_req;
  logic                window_end;
  chan_stat_t          chan_stat [NUM_CHAN];

  // control register and request feeder
  rst_ctrl_regs #(
    .NUM_CHAN      (NUM_CHAN),
    .RST_STAGES    (RST_STAGES),
    .WINDOW_CYCLES (WINDOW_CYCLES)
  ) u_ctrl (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .rst_n             (rst_n),
    .mm_req            (mm_req),
    .pll_locked        (pll_locked),
    .ctrl_word         (ctrl_word),
    .chan_rst_req      (chan_rst_req),
    .chip_rst_n        (chip_rst_n),
    .window_end        (window_end)
  );

  ////////////////////////////////////////
  // per channel monitors
  ////////////////////////////////////////
  for (genvar ch = 0; ch < NUM_CHAN; ch++)
  begin : g_chan
    chan_rst_mon #(
      .RST_STAGES (RST_STAGES)
    ) u_mon (
      .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
      .rst_n             (rst_n),
      .rst_req           (chan_rst_req[ch]),
      .window_end        (window_end),
      .rx_ready          (rx_ready[ch]),
      .clk_tick          (clk_tick[ch]),
      .chan_rst_n        (chan_rst_n[ch]),
      .stat              (chan_stat[ch])
    );
  end

  // readback drain
  status_readback #(
    .NUM_CHAN (NUM_CHAN)
  ) u_rdbk (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .rst_n             (rst_n),
    .mm_req            (mm_req),
    .ctrl_word         (ctrl_word),
    .pll_locked        (pll_locked),
    .chan_stat         (chan_stat),
    .mm_rd_data        (mm_rd_data),
    .mm_rd_data_v      (mm_rd_data_v)
  );

endmodule

// ==== verilog/status_readback.sv ====
////////////////////////////////////////
// register readback
// address decode, status formatting and
// the registered read data / valid pulse
////////////////////////////////////////
module status_readback
#(
  parameter int NUM_CHAN = 4
)
(
  input  logic                   iCLK_SERDES_RXREC,
  input  logic                   rst_n,
  input  clkrst_pkg::mm_req_t    mm_req,
  input  clkrst_pkg::mm_data_t   ctrl_word,
  input  logic                   pll_locked,
  input  clkrst_pkg::chan_stat_t chan_stat [NUM_CHAN],
  output clkrst_pkg::mm_data_t   mm_rd_data,
  output logic                   mm_rd_data_v
);

  import clkrst_pkg::*;

  mm_data_t status_word;
  mm_data_t rd_word;   // selected word, before the output register

  ////////////////////////////////////////
  // word formatting
  ////////////////////////////////////////
  always_comb
  begin
    status_word    = '0;
    status_word[0] = pll_locked;
    for (int i = 0; i < NUM_CHAN; i++)
      status_word[STAT_RX_READY_LSB + i] = chan_stat[i].rx_ready_sticky;
  end

  // address decode
  always_comb
  begin
    rd_word = '0;  // unmapped
    if (mm_req.addr == ADDR_CTRL)
      rd_word = ctrl_word;
    else if (mm_req.addr == ADDR_STATUS)
      rd_word = status_word;
    else
      for (int i = 0; i < NUM_CHAN; i++)
        if (mm_req.addr == mm_addr_t'(ADDR_FREQ_BASE + i))
          rd_word = mm_data_t'(chan_stat[i].freq_count);  // zero extended
  end

  ////////////////////////////////////////
  // read response
  ////////////////////////////////////////
  always_ff @(posedge iCLK_SERDES_RXREC)
  begin
    if (!rst_n)
      mm_rd_data_v <= 1'b0;
    else
      mm_rd_data_v <= mm_req.rd_en;  // one read per cycle, no stall
  end

  always_ff @(posedge iCLK_SERDES_RXREC)
  begin
    if (mm_req.rd_en)
      mm_rd_data <= rd_word;
  end

  // fixed one cycle read latency
  a_rd_latency: assert property (@(posedge iCLK_SERDES_RXREC) disable iff (!rst_n)
    mm_rd_data_v |-> $past(mm_req.rd_en));

endmodule

// ==== verilog/chan_rst_mon.sv ====
////////////////////////////////////////
// one receive channel monitor
// reset release chain, sticky rx_ready
// and windowed tick counter
////////////////////////////////////////
module chan_rst_mon
#(
  parameter int RST_STAGES = 3
)
(
  input  logic                   iCLK_SERDES_RXREC,
  input  logic                   rst_n,
  input  logic                   rst_req,     // registered request from control
  input  logic                   window_end,  // latch strobe, shared
  input  logic                   rx_ready,    // may flap without signal
  input  logic                   clk_tick,    // one strobe per measured clock
  output logic                   chan_rst_n,
  output clkrst_pkg::chan_stat_t stat
);

  import clkrst_pkg::*;

  logic [RST_STAGES-1:0] rel_sync;   // release chain
  logic                  hold;       // status forced to zero
  freq_cnt_t             tick_cnt;   // running count in current window
  freq_cnt_t             tick_next;

  ////////////////////////////////////////
  // reset release
  ////////////////////////////////////////
  // request clears the chain at once, release walks through all stages
  always_ff @(posedge iCLK_SERDES_RXREC)
  begin
    if (!rst_n || rst_req)
      rel_sync <= '0;
    else
      rel_sync <= {rel_sync[RST_STAGES-2:0], 1'b1};
  end

  assign chan_rst_n = rel_sync[RST_STAGES-1];

  // rst_req covers the edge where chan_rst_n is about to fall
  assign hold = ~rst_n | rst_req | ~chan_rst_n;

  ////////////////////////////////////////
  // tick counter and sticky ready
  ////////////////////////////////////////
  // saturate at all ones
  assign tick_next = (&tick_cnt) ? tick_cnt : tick_cnt + freq_cnt_t'(clk_tick);

  always_ff @(posedge iCLK_SERDES_RXREC)
  begin
    if (hold)
    begin
      tick_cnt <= '0;
      stat     <= '0;
    end
    else
    begin
      // set once, only a channel reset clears it
      if (rx_ready)
        stat.rx_ready_sticky <= 1'b1;

      if (window_end)
      begin
        stat.freq_count <= tick_next;  // this cycle's tick counts too
        tick_cnt        <= '0;
      end
      else
      begin
        tick_cnt <= tick_next;
      end
    end
  end

  // readback must never see stale data from a channel in reset
  a_stat_clear: assert property (@(posedge iCLK_SERDES_RXREC) disable iff (!rst_n)
    !chan_rst_n |-> stat == '0);

endmodule

// ==== verilog/rst_ctrl_regs.sv ====
////////////////////////////////////////
// reset control registers
// control word, pll gated reset requests,
// chip reset release and the shared
// measurement window timer
////////////////////////////////////////
module rst_ctrl_regs
#(
  parameter int NUM_CHAN      = 4,
  parameter int RST_STAGES    = 3,
  parameter int WINDOW_CYCLES = 1000
)
(
  input  logic                 iCLK_SERDES_RXREC,
  input  logic                 rst_n,
  input  clkrst_pkg::mm_req_t  mm_req,
  input  logic                 pll_locked,
  output clkrst_pkg::mm_data_t ctrl_word,     // current control register
  output logic [NUM_CHAN-1:0]  chan_rst_req,  // registered per channel request
  output logic                 chip_rst_n,
  output logic                 window_end     // one cycle, every window
);

  import clkrst_pkg::*;

  localparam int WIN_W = $clog2(WINDOW_CYCLES);

  typedef logic [WIN_W-1:0] win_cnt_t;

  localparam win_cnt_t WIN_LAST = win_cnt_t'(WINDOW_CYCLES - 1);

  // bits that exist in the control word
  localparam mm_data_t CTRL_MASK = (mm_data_t'(1) << CTRL_CHIP_RST_BIT) |
                                   ((mm_data_t'(1) << NUM_CHAN) - mm_data_t'(1));

  logic                  chip_term;   // chip level request, before the flop
  logic                  chip_req;
  logic [RST_STAGES-1:0] chip_sync;   // release chain, msb drives chip_rst_n
  win_cnt_t              win_cnt;

  ////////////////////////////////////////
  // parameter range
  ////////////////////////////////////////
  if (NUM_CHAN < 1 || NUM_CHAN > NUM_CHAN_MAX)
  begin : g_bad_num_chan
    $error("NUM_CHAN must be 1 to %0d", NUM_CHAN_MAX);
  end

  if (RST_STAGES < 2)
  begin : g_bad_rst_stages
    $error("RST_STAGES must be at least 2");
  end

  if (WINDOW_CYCLES < 2)
  begin : g_bad_window
    $error("WINDOW_CYCLES must be at least 2");
  end

  ////////////////////////////////////////
  // control register
  ////////////////////////////////////////
  always_ff @(posedge iCLK_SERDES_RXREC)
  begin
    if (!rst_n)
      ctrl_word <= '0;
    else if (mm_req.wr_en && mm_req.addr == ADDR_CTRL)
      ctrl_word <= mm_req.wr_data & CTRL_MASK;  // unused bits read back 0
  end

  // chip bit or lost lock resets everything
  assign chip_term = ctrl_word[CTRL_CHIP_RST_BIT] | ~pll_locked;

  // requests, one register stage
  always_ff @(posedge iCLK_SERDES_RXREC)
  begin
    if (!rst_n)
    begin
      chan_rst_req <= '1;
      chip_req     <= 1'b1;
    end
    else
    begin
      chan_rst_req <= ctrl_word[NUM_CHAN-1:0] | {NUM_CHAN{chip_term}};
      chip_req     <= chip_term;
    end
  end

  // chip release, asserts next edge and deasserts after the chain fills
  always_ff @(posedge iCLK_SERDES_RXREC)
  begin
    if (!rst_n || chip_req)
      chip_sync <= '0;
    else
      chip_sync <= {chip_sync[RST_STAGES-2:0], 1'b1};
  end

  assign chip_rst_n = chip_sync[RST_STAGES-1];

  ////////////////////////////////////////
  // window timer
  ////////////////////////////////////////
  always_ff @(posedge iCLK_SERDES_RXREC)
  begin
    if (!rst_n)
    begin
      win_cnt    <= '0;
      window_end <= 1'b0;
    end
    else if (win_cnt == WIN_LAST)
    begin
      win_cnt    <= '0;
      window_end <= 1'b1;  // strobe for all channels
    end
    else
    begin
      win_cnt    <= win_cnt + win_cnt_t'(1);
      window_end <= 1'b0;
    end
  end

  // channel counters latch once per window, never twice in a row
  a_window_single: assert property (@(posedge iCLK_SERDES_RXREC) disable iff (!rst_n)
    window_end |=> !window_end);

endmodule

// ==== verilog/clkrst_pkg.sv ====
////////////////////////////////////////
// clock/reset supervisor shared types
// widths, register map and the bundles
// passed between control, channel and
// readback logic
////////////////////////////////////////
package clkrst_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  typedef logic [3:0]  mm_addr_t;   // register word address
  typedef logic [31:0] mm_data_t;   // register data word
  typedef logic [15:0] freq_cnt_t;  // latched tick count per window

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////
  localparam mm_addr_t ADDR_CTRL      = 4'd0;  // rw, chip + channel reset bits
  localparam mm_addr_t ADDR_STATUS    = 4'd1;  // ro, pll lock + sticky ready
  localparam mm_addr_t ADDR_FREQ_BASE = 4'd2;  // ro, counter i at base + i

  // control word layout
  localparam int CTRL_CHIP_RST_BIT = 31;  // channel bits sit at 0 and up

  // status word layout, pll_locked in bit 0
  localparam int STAT_RX_READY_LSB = 8;

  // sticky bits use one status byte
  localparam int NUM_CHAN_MAX = 8;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////
  // register bus request, strobes are one cycle wide
  typedef struct packed {
    logic     wr_en;
    logic     rd_en;
    mm_addr_t addr;
    mm_data_t wr_data;
  } mm_req_t;

  // per channel status toward readback
  typedef struct packed {
    logic      rx_ready_sticky;  // first rx_ready seen since release
    freq_cnt_t freq_count;       // ticks in the last full window
  } chan_stat_t;

endpackage
